/* vlog.f */
design/afi_phy_pkg.sv
design/group_write_if.sv
design/afi_write_regroup.sv
design/dq_group_driver.sv
design/read_enable_shift.sv
design/read_latency_tracker.sv
design/read_valid_aggregator.sv
design/afi_phy_datapath.sv
tests/tb_clock_gen.sv
tests/tb_afi_phy_datapath.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_afi_phy_datapath
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG) || ! grep -qF '*** TEST PASSED ***' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_afi_phy_datapath.sv */
// Testbench for the PHY core-side datapath
// LFSR stimulus, a cycle model of the write and read-valid paths, and a watchdog
`timescale 1ns/1ps

module tb_afi_phy_datapath;
	import afi_phy_pkg::*;

	localparam int extra_shift = 1;
	localparam int clk_period = 100;
	localparam int write_beats = 40;
	localparam int pulses = 3;
	localparam int idle_gap = max_read_delay + extra_shift + 8;
	localparam int max_cycles = 8 + 2*write_beats + 4*pulses*(idle_gap+1) + 64;
	localparam int hist_depth = 1024;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	logic [afi_data_width-1:0] phy_ddio_dq;
	logic [afi_mask_width-1:0] phy_ddio_wrdata_mask;
	logic [afi_strobe_width-1:0] phy_ddio_wrdata_en;
	logic [afi_strobe_width-1:0] phy_ddio_dqs_en;
	logic [afi_strobe_width-1:0] phy_ddio_oct_ena;
	logic afi_rdata_en_full;
	logic [rd_latency_width-1:0] seq_read_latency_counter;
	logic [num_dqs_groups-1:0] seq_read_increment_vfifo_fr;
	logic seq_read_fifo_reset;
	logic [afi_data_width-1:0] phy_mem_dq;
	logic [afi_mask_width-1:0] phy_mem_dm;
	logic [num_dqs_groups*num_slots-1:0] phy_mem_dq_oe;
	logic [afi_strobe_width-1:0] phy_mem_dqs_oe;
	logic [afi_strobe_width-1:0] phy_mem_oct_on;
	logic [afi_rate_ratio-1:0] afi_rdata_valid;

	// Two-beat write pipeline, index 1 holds the beat now on the pins
	logic [afi_data_width-1:0] pipe_dq [2];
	logic [afi_mask_width-1:0] pipe_dm [2];
	logic [afi_strobe_width-1:0] pipe_en [2];
	logic [afi_strobe_width-1:0] pipe_dqs [2];
	logic [afi_strobe_width-1:0] pipe_oct [2];

	// Read inputs seen at each rising edge and each group's offset after it
	bit en_hist [hist_depth];
	int lat_hist [hist_depth];
	int off_hist [num_dqs_groups][hist_depth];
	int edge_cnt = 0;

	logic [31:0] lfsr_state = 32'h7281_9113;
	int test_errors, test_checks, total_errors, total_checks, tests_done;
	int rise_at;

	tb_clock_gen #(.clk_period(clk_period), .reset_cycles(4)) u_clock_gen (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk)
	);

	afi_phy_datapath #(.extra_vfifo_shift(extra_shift)) UUT (
		.pll_afi_clk                 (pll_afi_clk),
		.reset_n_afi_clk             (reset_n_afi_clk),
		.phy_ddio_dq                 (phy_ddio_dq),
		.phy_ddio_wrdata_mask        (phy_ddio_wrdata_mask),
		.phy_ddio_wrdata_en          (phy_ddio_wrdata_en),
		.phy_ddio_dqs_en             (phy_ddio_dqs_en),
		.phy_ddio_oct_ena            (phy_ddio_oct_ena),
		.afi_rdata_en_full           (afi_rdata_en_full),
		.seq_read_latency_counter    (seq_read_latency_counter),
		.seq_read_increment_vfifo_fr (seq_read_increment_vfifo_fr),
		.seq_read_fifo_reset         (seq_read_fifo_reset),
		.phy_mem_dq                  (phy_mem_dq),
		.phy_mem_dm                  (phy_mem_dm),
		.phy_mem_dq_oe               (phy_mem_dq_oe),
		.phy_mem_dqs_oe              (phy_mem_dqs_oe),
		.phy_mem_oct_on              (phy_mem_oct_on),
		.afi_rdata_valid             (afi_rdata_valid)
	);

	// Inputs change on the falling edge, so they are stable here
	always @(posedge pll_afi_clk) begin
		int prev;
		pipe_dq[1] = reset_n_afi_clk ? pipe_dq[0] : '0;
		pipe_dm[1] = reset_n_afi_clk ? pipe_dm[0] : '0;
		pipe_en[1] = reset_n_afi_clk ? pipe_en[0] : '0;
		pipe_dqs[1] = reset_n_afi_clk ? pipe_dqs[0] : '0;
		pipe_oct[1] = reset_n_afi_clk ? pipe_oct[0] : '0;
		pipe_dq[0] = reset_n_afi_clk ? phy_ddio_dq : '0;
		pipe_dm[0] = reset_n_afi_clk ? phy_ddio_wrdata_mask : '0;
		pipe_en[0] = reset_n_afi_clk ? phy_ddio_wrdata_en : '0;
		pipe_dqs[0] = reset_n_afi_clk ? phy_ddio_dqs_en : '0;
		pipe_oct[0] = reset_n_afi_clk ? phy_ddio_oct_ena : '0;
		if (edge_cnt < hist_depth) begin
			en_hist[edge_cnt] = afi_rdata_en_full;
			lat_hist[edge_cnt] = int'(seq_read_latency_counter);
			for (int g = 0; g < num_dqs_groups; g++) begin
				prev = (edge_cnt == 0) ? 0 : off_hist[g][edge_cnt-1];
				if (!reset_n_afi_clk || seq_read_fifo_reset) begin
					prev = 0;
				end else if (seq_read_increment_vfifo_fr[g] && prev < max_read_delay) begin
					prev = prev + 1;
				end
				off_hist[g][edge_cnt] = prev;
			end
		end
		edge_cnt++;
	end

	// Galois LFSR, one step per random bit
	function automatic logic [63:0] rand_bits(int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r[i] = lfsr_state[0];
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return r;
	endfunction

	// Valid after edge last needs every group's enable from its own tap back
	function automatic logic expected_valid(int last);
		logic v;
		int tap;
		int idx;
		v = (last >= 2);
		for (int g = 0; g < num_dqs_groups; g++) begin
			if (v) begin
				tap = lat_hist[last-1] + off_hist[g][last-2];
				tap = (tap > max_read_delay) ? max_read_delay : tap;
				idx = last - 2 - extra_shift - tap;
				v = (idx >= 0) ? en_hist[idx] : 1'b0;
			end
		end
		return v;
	endfunction

	task automatic compare(string test_name, string field, logic [63:0] exp_val,
		logic [63:0] act_val);
		test_checks++;
		if (exp_val !== act_val) begin
			test_errors++;
			$display("Error %s %s: expected %h, actual %h", test_name, field, exp_val, act_val);
		end
	endtask

	task automatic check_all_zero(string test_name);
		compare(test_name, "phy_mem_dq", 64'(0), 64'(phy_mem_dq));
		compare(test_name, "phy_mem_dm", 64'(0), 64'(phy_mem_dm));
		compare(test_name, "phy_mem_dq_oe", 64'(0), 64'(phy_mem_dq_oe));
		compare(test_name, "phy_mem_dqs_oe", 64'(0), 64'(phy_mem_dqs_oe));
		compare(test_name, "phy_mem_oct_on", 64'(0), 64'(phy_mem_oct_on));
		compare(test_name, "afi_rdata_valid", 64'(0), 64'(afi_rdata_valid));
	endtask

	// Waits for the next falling edge and checks every output against the model
	task automatic advance_cycle(string test_name);
		logic [afi_data_width-1:0] dq;
		logic [afi_mask_width-1:0] dm;
		logic [num_dqs_groups*num_slots-1:0] dq_oe;
		logic [afi_strobe_width-1:0] dqs_oe;
		logic [afi_strobe_width-1:0] oct_on;
		@(negedge pll_afi_clk);
		dq = '0;
		dm = '0;
		dq_oe = '0;
		for (int g = 0; g < num_dqs_groups; g++) begin
			for (int s = 0; s < num_slots; s++) begin
				if (pipe_en[1][(s/(num_slots/num_oe_slots))*num_dqs_groups+g]) begin
					dq_oe[g*num_slots+s] = 1'b1;
					dq[(g*num_slots+s)*group_dq_width +: group_dq_width] =
						pipe_dq[1][(s*num_dqs_groups+g)*group_dq_width +: group_dq_width];
					dm[g*num_slots+s] = pipe_dm[1][s*num_dqs_groups+g];
				end
			end
			for (int t = 0; t < num_oe_slots; t++) begin
				dqs_oe[g*num_oe_slots+t] = pipe_dqs[1][t*num_dqs_groups+g];
				oct_on[g*num_oe_slots+t] = pipe_oct[1][t*num_dqs_groups+g] &
					~pipe_en[1][t*num_dqs_groups+g];
			end
		end
		compare(test_name, "phy_mem_dq", 64'(dq), 64'(phy_mem_dq));
		compare(test_name, "phy_mem_dm", 64'(dm), 64'(phy_mem_dm));
		compare(test_name, "phy_mem_dq_oe", 64'(dq_oe), 64'(phy_mem_dq_oe));
		compare(test_name, "phy_mem_dqs_oe", 64'(dqs_oe), 64'(phy_mem_dqs_oe));
		compare(test_name, "phy_mem_oct_on", 64'(oct_on), 64'(phy_mem_oct_on));
		compare(test_name, "afi_rdata_valid",
			64'({afi_rate_ratio{expected_valid(edge_cnt-1)}}), 64'(afi_rdata_valid));
	endtask

	task automatic finish_test(string test_name);
		$display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		tests_done++;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic drive_random_beat(logic [afi_strobe_width-1:0] wr_en);
		phy_ddio_dq = rand_bits(afi_data_width);
		phy_ddio_wrdata_mask = afi_mask_width'(rand_bits(afi_mask_width));
		phy_ddio_wrdata_en = wr_en;
		phy_ddio_dqs_en = afi_strobe_width'(rand_bits(afi_strobe_width)) & wr_en;
		phy_ddio_oct_ena = afi_strobe_width'(rand_bits(afi_strobe_width));
	endtask

	// Drives one enable pulse and returns the edges until valid rises
	task automatic pulse_and_measure(string test_name, output int delay);
		afi_rdata_en_full = 1'b1;
		delay = -1;
		for (int c = 1; c <= idle_gap + 1; c++) begin
			advance_cycle(test_name);
			afi_rdata_en_full = 1'b0;
			if (afi_rdata_valid[0] && delay < 0) begin
				delay = c - 1;
			end
		end
	endtask

	initial begin
		phy_ddio_dq = '0;
		phy_ddio_wrdata_mask = '0;
		phy_ddio_wrdata_en = '0;
		phy_ddio_dqs_en = '0;
		phy_ddio_oct_ena = '0;
		afi_rdata_en_full = 1'b0;
		seq_read_latency_counter = '0;
		seq_read_increment_vfifo_fr = '0;
		seq_read_fifo_reset = 1'b0;

		do begin
			@(negedge pll_afi_clk);
			check_all_zero("reset_values");
		end while (reset_n_afi_clk !== 1'b1);
		repeat (3) advance_cycle("reset_values");
		finish_test("reset_values");

		for (int i = 0; i < write_beats; i++) begin
			drive_random_beat('1);
			advance_cycle("write_regroup");
		end
		finish_test("write_regroup");

		for (int i = 0; i < write_beats; i++) begin
			drive_random_beat(afi_strobe_width'(rand_bits(afi_strobe_width)));
			advance_cycle("enable_masking");
		end
		drive_random_beat('0);
		repeat (2) advance_cycle("enable_masking");
		finish_test("enable_masking");

		for (int r = 0; r < 2; r++) begin
			seq_read_latency_counter = rd_latency_width'(rand_bits(rd_latency_width));
			for (int p = 0; p < pulses; p++) begin
				pulse_and_measure("read_latency", rise_at);
				compare("read_latency", "valid_delay",
					64'(extra_shift + int'(seq_read_latency_counter) + 2), 64'(rise_at));
			end
		end
		finish_test("read_latency");

		// One group runs a few taps later than the other
		seq_read_latency_counter = rd_latency_width'(rand_bits(4));
		seq_read_increment_vfifo_fr = num_dqs_groups'(1) << rand_bits(1);
		repeat (int'(rand_bits(2)) + 1) advance_cycle("calib_offset");
		seq_read_increment_vfifo_fr = '0;
		for (int p = 0; p < pulses; p++) begin
			pulse_and_measure("calib_offset", rise_at);
		end
		afi_rdata_en_full = 1'b1;
		repeat (8) advance_cycle("calib_offset");
		afi_rdata_en_full = 1'b0;
		repeat (idle_gap) advance_cycle("calib_offset");
		seq_read_fifo_reset = 1'b1;
		advance_cycle("calib_offset");
		seq_read_fifo_reset = 1'b0;
		pulse_and_measure("calib_offset", rise_at);
		compare("calib_offset", "valid_delay",
			64'(extra_shift + int'(seq_read_latency_counter) + 2), 64'(rise_at));
		finish_test("calib_offset");

		$display("Summary: %0d tests, %0d checks, %0d errors", tests_done, total_checks,
			total_errors);
		if (total_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#((max_cycles + 200) * clk_period);
		$display("Timeout: the tests did not finish in the expected number of cycles");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* tests/tb_clock_gen.sv */
// Testbench clock and power-on reset for the datapath
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int clk_period = 100,
	parameter int reset_cycles = 4
) (
	output logic pll_afi_clk,
	output logic reset_n_afi_clk
);

	initial begin
		pll_afi_clk = 1'b0;
		forever #(clk_period/2) pll_afi_clk = ~pll_afi_clk;
	end

	// Release falls between a falling edge and the next rising edge
	initial begin
		reset_n_afi_clk = 1'b0;
		#(reset_cycles*clk_period + clk_period/4);
		reset_n_afi_clk = 1'b1;
	end

endmodule

/* design/afi_phy_datapath.sv */
// Top level of the PHY core-side datapath
// Write regrouping and output stage, read-enable delay and read-valid timing
`timescale 1ns/1ps

module afi_phy_datapath #(
	parameter int extra_vfifo_shift = 1
) (
	input  logic                                     pll_afi_clk,
	input  logic                                     reset_n_afi_clk,
	input  logic [afi_phy_pkg::afi_data_width-1:0]   phy_ddio_dq,
	input  logic [afi_phy_pkg::afi_mask_width-1:0]   phy_ddio_wrdata_mask,
	input  logic [afi_phy_pkg::afi_strobe_width-1:0] phy_ddio_wrdata_en,
	input  logic [afi_phy_pkg::afi_strobe_width-1:0] phy_ddio_dqs_en,
	input  logic [afi_phy_pkg::afi_strobe_width-1:0] phy_ddio_oct_ena,
	input  logic                                     afi_rdata_en_full,
	input  logic [afi_phy_pkg::rd_latency_width-1:0] seq_read_latency_counter,
	input  logic [afi_phy_pkg::num_dqs_groups-1:0]   seq_read_increment_vfifo_fr,
	input  logic                                     seq_read_fifo_reset,
	output logic [afi_phy_pkg::afi_data_width-1:0]   phy_mem_dq,
	output logic [afi_phy_pkg::afi_mask_width-1:0]   phy_mem_dm,
	output logic [afi_phy_pkg::num_dqs_groups*afi_phy_pkg::num_slots-1:0] phy_mem_dq_oe,
	output logic [afi_phy_pkg::afi_strobe_width-1:0] phy_mem_dqs_oe,
	output logic [afi_phy_pkg::afi_strobe_width-1:0] phy_mem_oct_on,
	output logic [afi_phy_pkg::afi_rate_ratio-1:0]   afi_rdata_valid
);

	group_write_if wr_bus ();

	logic rdata_en_shifted;

	afi_write_regroup u_write_regroup (
		.pll_afi_clk          (pll_afi_clk),
		.reset_n_afi_clk      (reset_n_afi_clk),
		.phy_ddio_dq          (phy_ddio_dq),
		.phy_ddio_wrdata_mask (phy_ddio_wrdata_mask),
		.phy_ddio_wrdata_en   (phy_ddio_wrdata_en),
		.phy_ddio_dqs_en      (phy_ddio_dqs_en),
		.phy_ddio_oct_ena     (phy_ddio_oct_ena),
		.wr                   (wr_bus)
	);

	dq_group_driver u_group_driver (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.wr              (wr_bus),
		.phy_mem_dq      (phy_mem_dq),
		.phy_mem_dm      (phy_mem_dm),
		.phy_mem_dq_oe   (phy_mem_dq_oe),
		.phy_mem_dqs_oe  (phy_mem_dqs_oe),
		.phy_mem_oct_on  (phy_mem_oct_on)
	);

	read_enable_shift #(
		.extra_vfifo_shift (extra_vfifo_shift)
	) u_enable_shift (
		.pll_afi_clk       (pll_afi_clk),
		.reset_n_afi_clk   (reset_n_afi_clk),
		.afi_rdata_en_full (afi_rdata_en_full),
		.rdata_en_shifted  (rdata_en_shifted)
	);

	read_valid_aggregator u_valid_aggregator (
		.pll_afi_clk                 (pll_afi_clk),
		.reset_n_afi_clk             (reset_n_afi_clk),
		.rdata_en_shifted            (rdata_en_shifted),
		.seq_read_latency_counter    (seq_read_latency_counter),
		.seq_read_increment_vfifo_fr (seq_read_increment_vfifo_fr),
		.seq_read_fifo_reset         (seq_read_fifo_reset),
		.afi_rdata_valid             (afi_rdata_valid)
	);

endmodule

/* design/read_valid_aggregator.sv */
// Per-group read latency trackers and the combined AFI read-valid
// Valid is only reported once every group has its data window open
`timescale 1ns/1ps

module read_valid_aggregator (
	input  logic                                     pll_afi_clk,
	input  logic                                     reset_n_afi_clk,
	input  logic                                     rdata_en_shifted,
	input  logic [afi_phy_pkg::rd_latency_width-1:0] seq_read_latency_counter,
	input  logic [afi_phy_pkg::num_dqs_groups-1:0]   seq_read_increment_vfifo_fr,
	input  logic                                     seq_read_fifo_reset,
	output logic [afi_phy_pkg::afi_rate_ratio-1:0]   afi_rdata_valid
);
	import afi_phy_pkg::*;

	logic [num_dqs_groups-1:0] group_valid;

	generate
		for (genvar g = 0; g < num_dqs_groups; g++) begin : g_grp
			read_latency_tracker u_tracker (
				.pll_afi_clk       (pll_afi_clk),
				.reset_n_afi_clk   (reset_n_afi_clk),
				.rdata_en_shifted  (rdata_en_shifted),
				.rd_latency        (seq_read_latency_counter),
				.inc_offset        (seq_read_increment_vfifo_fr[g]),
				.fifo_reset        (seq_read_fifo_reset),
				.group_rdata_valid (group_valid[g])
			);
		end
	endgenerate

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			afi_rdata_valid <= '0;
		end else begin
			afi_rdata_valid <= {afi_rate_ratio{&group_valid}};
		end
	end

endmodule

/* design/read_latency_tracker.sv */
// Read-valid delay for one DQS group
// Holds the enable history and the calibration offset set by the sequencer
`timescale 1ns/1ps

module read_latency_tracker (
	input  logic                                     pll_afi_clk,
	input  logic                                     reset_n_afi_clk,
	input  logic                                     rdata_en_shifted,
	input  logic [afi_phy_pkg::rd_latency_width-1:0] rd_latency,
	input  logic                                     inc_offset,
	input  logic                                     fifo_reset,
	output logic                                     group_rdata_valid
);
	import afi_phy_pkg::*;

	logic [max_read_delay:0]     hist_q;
	logic [rd_latency_width-1:0] offset_q;
	logic [rd_latency_width:0]   tap_sum;
	logic [rd_latency_width-1:0] tap;

	// Calibration offset, stepped up one tap per sequencer pulse
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			offset_q <= '0;
		end else if (fifo_reset) begin
			offset_q <= '0;
		end else if (inc_offset && (offset_q != rd_latency_width'(max_read_delay))) begin
			offset_q <= offset_q + 1'b1;
		end
	end

	// hist_q[k] holds the enable sampled k edges ago
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			hist_q <= '0;
		end else begin
			hist_q <= {hist_q[max_read_delay-1:0], rdata_en_shifted};
		end
	end

	always_comb begin
		tap_sum = {1'b0, rd_latency} + {1'b0, offset_q};
		if (tap_sum > (rd_latency_width+1)'(max_read_delay)) begin
			tap = rd_latency_width'(max_read_delay);
		end else begin
			tap = tap_sum[rd_latency_width-1:0];
		end
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			group_rdata_valid <= 1'b0;
		end else begin
			group_rdata_valid <= hist_q[tap];
		end
	end

	// Between FIFO resets the offset only grows and stays within the history
	a_offset_bounded: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		!fifo_reset |=> (offset_q >= $past(offset_q)) && (offset_q <= max_read_delay)
	) else $error("Read offset moved down or past the last delay tap");

endmodule

/* design/read_enable_shift.sv */
// Extra delay line on the full-rate read enable
// A length of zero passes the enable straight through
`timescale 1ns/1ps

module read_enable_shift #(
	parameter int extra_vfifo_shift = 1
) (
	input  logic pll_afi_clk,
	input  logic reset_n_afi_clk,
	input  logic afi_rdata_en_full,
	output logic rdata_en_shifted
);

	generate
		if (extra_vfifo_shift == 0) begin : g_no_shift
			assign rdata_en_shifted = afi_rdata_en_full;
		end else begin : g_shift
			logic [extra_vfifo_shift-1:0] shift_q;

			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
				if (!reset_n_afi_clk) begin
					shift_q <= '0;
				end else begin
					shift_q[0] <= afi_rdata_en_full;
					for (int i = 1; i < extra_vfifo_shift; i++) begin
						shift_q[i] <= shift_q[i-1];
					end
				end
			end

			// Oldest stage feeds the latency trackers
			assign rdata_en_shifted = shift_q[extra_vfifo_shift-1];
		end
	endgenerate

endmodule

/* design/dq_group_driver.sv */
// Output register stage for every DQS group
// Masks disabled slots, widens the enables and derives dynamic OCT
`timescale 1ns/1ps

module dq_group_driver (
	input  logic                                     pll_afi_clk,
	input  logic                                     reset_n_afi_clk,
	group_write_if.sink                              wr,
	output logic [afi_phy_pkg::afi_data_width-1:0]   phy_mem_dq,
	output logic [afi_phy_pkg::afi_mask_width-1:0]   phy_mem_dm,
	output logic [afi_phy_pkg::num_dqs_groups*afi_phy_pkg::num_slots-1:0] phy_mem_dq_oe,
	output logic [afi_phy_pkg::afi_strobe_width-1:0] phy_mem_dqs_oe,
	output logic [afi_phy_pkg::afi_strobe_width-1:0] phy_mem_oct_on
);
	import afi_phy_pkg::*;

	localparam int slots_per_oe = num_slots / num_oe_slots;
	localparam int group_dq_bits = num_slots * group_dq_width;
	localparam int group_dm_bits = num_slots * group_dm_width;

	logic [afi_data_width-1:0]           dq_next;
	logic [afi_mask_width-1:0]           dm_next;
	logic [num_dqs_groups*num_slots-1:0] dq_oe_next;
	logic [afi_strobe_width-1:0]         dqs_oe_next;
	logic [afi_strobe_width-1:0]         oct_on_next;

	always_comb begin
		for (int g = 0; g < num_dqs_groups; g++) begin
			for (int s = 0; s < num_slots; s++) begin
				// Each enable slot covers two consecutive data slots
				dq_oe_next[g*num_slots+s] = wr.oe[g][s/slots_per_oe];
				dq_next[g*group_dq_bits+s*group_dq_width +: group_dq_width] =
					wr.oe[g][s/slots_per_oe] ?
					wr.dq[g][s*group_dq_width +: group_dq_width] : '0;
				dm_next[g*group_dm_bits+s*group_dm_width +: group_dm_width] =
					wr.oe[g][s/slots_per_oe] ?
					wr.dm[g][s*group_dm_width +: group_dm_width] : '0;
			end
			for (int t = 0; t < num_oe_slots; t++) begin
				dqs_oe_next[g*num_oe_slots+t] = wr.dqs_en[g][t];
				// Termination stays off while the group drives its own pins
				oct_on_next[g*num_oe_slots+t] = wr.oct_ena[g][t] & ~wr.oe[g][t];
			end
		end
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			phy_mem_dq <= '0;
			phy_mem_dm <= '0;
			phy_mem_dq_oe <= '0;
			phy_mem_dqs_oe <= '0;
			phy_mem_oct_on <= '0;
		end else begin
			phy_mem_dq <= dq_next;
			phy_mem_dm <= dm_next;
			phy_mem_dq_oe <= dq_oe_next;
			phy_mem_dqs_oe <= dqs_oe_next;
			phy_mem_oct_on <= oct_on_next;
		end
	end

endmodule

/* design/afi_write_regroup.sv */
// Core-to-periphery register for the AFI write beat
// Reorders the slot-major AFI buses into per-group slot bundles
`timescale 1ns/1ps

module afi_write_regroup (
	input  logic                                     pll_afi_clk,
	input  logic                                     reset_n_afi_clk,
	input  logic [afi_phy_pkg::afi_data_width-1:0]   phy_ddio_dq,
	input  logic [afi_phy_pkg::afi_mask_width-1:0]   phy_ddio_wrdata_mask,
	input  logic [afi_phy_pkg::afi_strobe_width-1:0] phy_ddio_wrdata_en,
	input  logic [afi_phy_pkg::afi_strobe_width-1:0] phy_ddio_dqs_en,
	input  logic [afi_phy_pkg::afi_strobe_width-1:0] phy_ddio_oct_ena,
	group_write_if.source                            wr
);
	import afi_phy_pkg::*;

	logic [afi_data_width-1:0]   dq_q;
	logic [afi_mask_width-1:0]   mask_q;
	logic [afi_strobe_width-1:0] wrdata_en_q;
	logic [afi_strobe_width-1:0] dqs_en_q;
	logic [afi_strobe_width-1:0] oct_ena_q;

	// Core-to-periphery capture of the write data and mask
	always_ff @(posedge pll_afi_clk) begin
		dq_q <= phy_ddio_dq;
		mask_q <= phy_ddio_wrdata_mask;
	end

	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			wrdata_en_q <= '0;
			dqs_en_q <= '0;
			oct_ena_q <= '0;
		end else begin
			wrdata_en_q <= phy_ddio_wrdata_en;
			dqs_en_q <= phy_ddio_dqs_en;
			oct_ena_q <= phy_ddio_oct_ena;
		end
	end

	// AFI buses are ordered by time slot first, then by DQS group
	always_comb begin
		for (int g = 0; g < num_dqs_groups; g++) begin
			for (int s = 0; s < num_slots; s++) begin
				wr.dq[g][s*group_dq_width +: group_dq_width] =
					dq_q[(s*num_dqs_groups+g)*group_dq_width +: group_dq_width];
				wr.dm[g][s*group_dm_width +: group_dm_width] =
					mask_q[(s*num_dqs_groups+g)*group_dm_width +: group_dm_width];
			end
			for (int t = 0; t < num_oe_slots; t++) begin
				wr.oe[g][t] = wrdata_en_q[t*num_dqs_groups+g];
				wr.dqs_en[g][t] = dqs_en_q[t*num_dqs_groups+g];
				wr.oct_ena[g][t] = oct_ena_q[t*num_dqs_groups+g];
			end
		end
	end

	// A strobe burst must never run in a slot where the DQ pins are not driven
	a_dqs_needs_oe: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(dqs_en_q & ~wrdata_en_q) == '0
	) else $error("DQS enable set in a slot without write data enable");

endmodule

/* design/group_write_if.sv */
// Interface for one registered AFI write beat split by DQS group
// Source side is the C2P stage, sink side the per-group output stage
`timescale 1ns/1ps

interface group_write_if;
	import afi_phy_pkg::*;

	group_dq_t dq [num_dqs_groups];
	group_dm_t dm [num_dqs_groups];
	group_en_t oe [num_dqs_groups];
	group_en_t dqs_en [num_dqs_groups];
	group_en_t oct_ena [num_dqs_groups];

	modport source (
		output dq,
		output dm,
		output oe,
		output dqs_en,
		output oct_ena
	);

	modport sink (
		input dq,
		input dm,
		input oe,
		input dqs_en,
		input oct_ena
	);

endinterface

/* design/afi_phy_pkg.sv */
// Widths and counts shared by the PHY core-side datapath
// Per-group bundle types used on the regrouped write path
package afi_phy_pkg;

	// Group and slot geometry of one AFI beat
	localparam int num_dqs_groups = 2;
	localparam int num_slots = 4;
	localparam int num_oe_slots = 2;
	localparam int group_dq_width = 8;
	localparam int group_dm_width = 1;

	// AFI bus widths follow from the geometry above
	localparam int afi_data_width = num_slots * num_dqs_groups * group_dq_width;
	localparam int afi_mask_width = num_slots * num_dqs_groups * group_dm_width;
	localparam int afi_strobe_width = num_oe_slots * num_dqs_groups;
	localparam int afi_rate_ratio = 2;

	// Read-valid delay control
	localparam int rd_latency_width = 5;
	localparam int max_read_delay = 31;

	// One group's data for all slots, slot 0 in the low bits
	typedef logic [num_slots*group_dq_width-1:0] group_dq_t;

	// One group's mask bits for all slots
	typedef logic [num_slots*group_dm_width-1:0] group_dm_t;

	// Enable pair, one bit per enable slot
	typedef logic [num_oe_slots-1:0] group_en_t;

endpackage
